//--- shouse_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Memory map and widths shared by the subsystem. Windows are aligned to
// their own size, so a window is matched on the upper address bits only.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package shouse_pkg;

    localparam int BADDR_W = 16;
    localparam int DATA_W  = 8;
    localparam int TRI_AW  = 11;
    localparam int KEY_AW  = 3;
    localparam int RAM_AW  = 13;

    // Main-bus windows
    localparam logic [BADDR_W-1:0] TRI_BASE = 16'h4000;
    localparam logic [BADDR_W-1:0] KEY_BASE = 16'h5000;
    localparam logic [BADDR_W-1:0] RAM_BASE = 16'h6000;

    // Key chip register offsets
    localparam logic [KEY_AW-1:0] KEY_ID_REG   = 3'd0;
    localparam logic [KEY_AW-1:0] KEY_MULA_REG = 3'd4;
    localparam logic [KEY_AW-1:0] KEY_MULB_REG = 3'd5;
    localparam logic [KEY_AW-1:0] KEY_PLO_REG  = 3'd6;
    localparam logic [KEY_AW-1:0] KEY_PHI_REG  = 3'd7;

    // Enable cycle and the phase of each enable within it
    localparam int             CEN_DIV = 8;
    localparam int             CEN_W   = $clog2(CEN_DIV);
    localparam logic [1:0]     MAIN_PH = 2'd3;
    localparam logic [1:0]     SND_PH  = 2'd1;
    localparam logic [CEN_W-1:0] MCU_PH = 3'd5;

endpackage

`default_nettype wire

//--- shouse_cenloop.sv
////////////////////////////////////////////////////////////////////////////
// Enables are combinational from the phase counter. A cen_main pulse that
// falls while busy is high is dropped, never queued.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module shouse_cenloop(
    input  wire  clk,
    input  wire  rst,
    input  wire  busy,
    output logic cen_main,
    output logic cen_snd,
    output logic cen_mcu,
    output logic snd_sel
);
    import shouse_pkg::*;

    logic [CEN_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt == CEN_W'(CEN_DIV-1)) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'd1;
        end
    end

    // Main and sound run at a quarter of clk, two clocks apart
    assign cen_main = (cnt[1:0] == MAIN_PH) & ~busy;
    assign cen_snd  = cnt[1:0] == SND_PH;

    // MCU gets one pulse per cycle, in the second half
    assign cen_mcu  = cnt == MCU_PH;

    // Sound owns port B in the first half of the cycle,
    // the MCU in the second half
    assign snd_sel  = ~cnt[CEN_W-1];

endmodule

`default_nettype wire

//--- shouse_decoder.sv
////////////////////////////////////////////////////////////////////////////
// At most one select is active. The read mux follows the select of the
// previous clock, matching the one-clock read latency of every block.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module shouse_decoder(
    input  wire                           clk,
    input  wire                           rst,
    input  wire [shouse_pkg::BADDR_W-1:0] baddr,
    input  wire                           bus_cs,
    output logic                          tri_cs,
    output logic                          key_cs,
    output logic                          ram_cs,
    input  wire [shouse_pkg::DATA_W-1:0]  tri_dout,
    input  wire [shouse_pkg::DATA_W-1:0]  key_dout,
    input  wire [shouse_pkg::DATA_W-1:0]  ram_dout,
    output logic [shouse_pkg::DATA_W-1:0] bdin
);
    import shouse_pkg::*;

    logic       tri_hit, key_hit, ram_hit;
    logic [2:0] sel_q;

    // Windows are size aligned, compare the bits above the window
    assign tri_hit = baddr[BADDR_W-1:TRI_AW] == TRI_BASE[BADDR_W-1:TRI_AW];
    assign key_hit = baddr[BADDR_W-1:KEY_AW] == KEY_BASE[BADDR_W-1:KEY_AW];
    assign ram_hit = baddr[BADDR_W-1:RAM_AW] == RAM_BASE[BADDR_W-1:RAM_AW];

    assign tri_cs = bus_cs & tri_hit;
    assign key_cs = bus_cs & key_hit;
    assign ram_cs = bus_cs & ram_hit;

    // One-hot: bit 0 tri-RAM, bit 1 key, bit 2 work RAM
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q <= '0;
        end else begin
            sel_q <= {ram_cs, key_cs, tri_cs};
        end
    end

    always_comb begin
        if (sel_q[0]) begin
            bdin = tri_dout;
        end else if (sel_q[1]) begin
            bdin = key_dout;
        end else if (sel_q[2]) begin
            bdin = ram_dout;
        end else begin
            // Open bus
            bdin = '1;
        end
    end

endmodule

`default_nettype wire

//--- shouse_triram.sv
////////////////////////////////////////////////////////////////////////////
// 2 KiB shared RAM. Port B is split between sound and MCU by snd_sel.
// Same-address writes on both ports in one clock keep the port B data.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module shouse_triram(
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          cen_main,
    input  wire                          cen_snd,
    input  wire                          cen_mcu,
    input  wire                          snd_sel,
    // Main bus
    input  wire                          bus_cs,
    input  wire                          brnw,
    input  wire [shouse_pkg::TRI_AW-1:0] baddr,
    input  wire [shouse_pkg::DATA_W-1:0] bdout,
    output logic [shouse_pkg::DATA_W-1:0] bdin,
    // MCU
    input  wire                          mcu_cs,
    input  wire                          mcu_rnw,
    input  wire [shouse_pkg::TRI_AW-1:0] mcu_addr,
    input  wire [shouse_pkg::DATA_W-1:0] mcu_dout,
    output logic [shouse_pkg::DATA_W-1:0] mcu_din,
    // Sound CPU
    input  wire                          snd_cs,
    input  wire                          snd_rnw,
    input  wire [shouse_pkg::TRI_AW-1:0] snd_addr,
    input  wire [shouse_pkg::DATA_W-1:0] snd_dout,
    output logic [shouse_pkg::DATA_W-1:0] snd_din
);
    import shouse_pkg::*;

    logic [DATA_W-1:0] mem [0:2**TRI_AW-1];
    logic              a_we, b_we, mcu_slot, snd_slot;
    logic [TRI_AW-1:0] b_addr;
    logic [DATA_W-1:0] b_wdata;

    assign a_we = cen_main & bus_cs & ~brnw;

    // Port B ownership follows the slot select
    assign mcu_slot = cen_mcu & ~snd_sel & mcu_cs;
    assign snd_slot = cen_snd &  snd_sel & snd_cs;
    assign b_addr   = snd_sel ? snd_addr : mcu_addr;
    assign b_wdata  = snd_sel ? snd_dout : mcu_dout;
    assign b_we     = (snd_slot & ~snd_rnw) | (mcu_slot & ~mcu_rnw);

    always_ff @(posedge clk) begin
        if (a_we) begin
            mem[baddr] <= bdout;
        end
        // Port B last, so it wins a same-address clash
        if (b_we) begin
            mem[b_addr] <= b_wdata;
        end
    end

    // Each requester keeps its own read register
    always_ff @(posedge clk) begin
        if (rst) begin
            bdin    <= '0;
            mcu_din <= '0;
            snd_din <= '0;
        end else begin
            if (bus_cs) begin
                bdin <= mem[baddr];
            end
            if (mcu_slot) begin
                mcu_din <= mem[b_addr];
            end
            if (snd_slot) begin
                snd_din <= mem[b_addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- shouse_key.sv
////////////////////////////////////////////////////////////////////////////
// The ID is only loaded from the ROM header, bus writes to it are ignored.
// Product registers at offsets 6 and 7 are read only.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module shouse_key(
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           cs,
    input  wire                           rnw,
    input  wire [shouse_pkg::KEY_AW-1:0]  addr,
    input  wire [shouse_pkg::DATA_W-1:0]  din,
    output logic [shouse_pkg::DATA_W-1:0] dout,
    input  wire                           cen,
    input  wire                           prog_en,
    input  wire                           prog_wr,
    input  wire [shouse_pkg::KEY_AW-1:0]  prog_addr,
    input  wire [shouse_pkg::DATA_W-1:0]  prog_data
);
    import shouse_pkg::*;

    // Offsets 0 to 5, ID at 0 and the operands at 4 and 5
    logic [DATA_W-1:0]   regs [0:KEY_PLO_REG-1];
    logic [2*DATA_W-1:0] prod_q;
    logic                bus_we, hdr_we;

    assign bus_we = cs & cen & ~rnw & (addr != KEY_ID_REG) & (addr < KEY_PLO_REG);
    assign hdr_we = prog_en & prog_wr & (prog_addr == KEY_ID_REG);

    always_ff @(posedge clk) begin
        if (bus_we) begin
            regs[addr] <= din;
        end
        if (hdr_we) begin
            regs[KEY_ID_REG] <= prog_data;
        end
    end

    // Unsigned multiplier, one clock behind the operands
    always_ff @(posedge clk) begin
        prod_q <= {{DATA_W{1'b0}}, regs[KEY_MULA_REG]} *
                  {{DATA_W{1'b0}}, regs[KEY_MULB_REG]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dout <= '0;
        end else if (cs) begin
            case (addr)
                KEY_PLO_REG: dout <= prod_q[DATA_W-1:0];
                KEY_PHI_REG: dout <= prod_q[2*DATA_W-1:DATA_W];
                default:     dout <= regs[addr];
            endcase
        end
    end

endmodule

`default_nettype wire

//--- shouse_sub.sv
////////////////////////////////////////////////////////////////////////////
// Shared-bus core without CPUs. Work RAM sits outside and answers on
// ram_dout one clock after ram_cs.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module shouse_sub(
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           busy,
    // Main bus
    input  wire [shouse_pkg::BADDR_W-1:0] baddr,
    input  wire                           brnw,
    input  wire [shouse_pkg::DATA_W-1:0]  bdout,
    input  wire                           bus_cs,
    output logic [shouse_pkg::DATA_W-1:0] bdin,
    output logic                          ram_cs,
    input  wire [shouse_pkg::DATA_W-1:0]  ram_dout,
    // MCU
    input  wire                           mcu_cs,
    input  wire                           mcu_rnw,
    input  wire [shouse_pkg::TRI_AW-1:0]  mcu_addr,
    input  wire [shouse_pkg::DATA_W-1:0]  mcu_dout,
    output logic [shouse_pkg::DATA_W-1:0] mcu_din,
    // Sound CPU
    input  wire                           snd_cs,
    input  wire                           snd_rnw,
    input  wire [shouse_pkg::TRI_AW-1:0]  snd_addr,
    input  wire [shouse_pkg::DATA_W-1:0]  snd_dout,
    output logic [shouse_pkg::DATA_W-1:0] snd_din,
    // ROM header
    input  wire                           prog_en,
    input  wire                           prog_wr,
    input  wire [shouse_pkg::KEY_AW-1:0]  prog_addr,
    input  wire [shouse_pkg::DATA_W-1:0]  prog_data,
    // Clock enables
    output logic                          cen_main,
    output logic                          cen_snd,
    output logic                          cen_mcu,
    output logic                          snd_sel
);
    import shouse_pkg::*;

    logic              tri_cs, key_cs;
    logic [DATA_W-1:0] tri_dout, key_dout;

    shouse_cenloop u_cen(
        .clk      ( clk      ),
        .rst      ( rst      ),
        .busy     ( busy     ),
        .cen_main ( cen_main ),
        .cen_snd  ( cen_snd  ),
        .cen_mcu  ( cen_mcu  ),
        .snd_sel  ( snd_sel  )
    );

    shouse_decoder u_dec(
        .clk      ( clk      ),
        .rst      ( rst      ),
        .baddr    ( baddr    ),
        .bus_cs   ( bus_cs   ),
        .tri_cs   ( tri_cs   ),
        .key_cs   ( key_cs   ),
        .ram_cs   ( ram_cs   ),
        .tri_dout ( tri_dout ),
        .key_dout ( key_dout ),
        .ram_dout ( ram_dout ),
        .bdin     ( bdin     )
    );

    // Only the offset within the 2 KiB window reaches the RAM
    shouse_triram u_triram(
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cen_main ( cen_main ),
        .cen_snd  ( cen_snd  ),
        .cen_mcu  ( cen_mcu  ),
        .snd_sel  ( snd_sel  ),
        .bus_cs   ( tri_cs   ),
        .brnw     ( brnw     ),
        .baddr    ( baddr[TRI_AW-1:0] ),
        .bdout    ( bdout    ),
        .bdin     ( tri_dout ),
        .mcu_cs   ( mcu_cs   ),
        .mcu_rnw  ( mcu_rnw  ),
        .mcu_addr ( mcu_addr ),
        .mcu_dout ( mcu_dout ),
        .mcu_din  ( mcu_din  ),
        .snd_cs   ( snd_cs   ),
        .snd_rnw  ( snd_rnw  ),
        .snd_addr ( snd_addr ),
        .snd_dout ( snd_dout ),
        .snd_din  ( snd_din  )
    );

    shouse_key u_key(
        .clk       ( clk       ),
        .rst       ( rst       ),
        .cs        ( key_cs    ),
        .rnw       ( brnw      ),
        .addr      ( baddr[KEY_AW-1:0] ),
        .din       ( bdout     ),
        .dout      ( key_dout  ),
        .cen       ( cen_main  ),
        .prog_en   ( prog_en   ),
        .prog_wr   ( prog_wr   ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data )
    );

endmodule

`default_nettype wire

//--- shouse_tb.sv
////////////////////////////////////////////////////////////////////////////
// Checks the enables after reset, replays shouse_testdata.txt from the
// project root, then runs the multiplier and busy-stall checks.
// Accesses wait for their enable edge.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module shouse_tb;
    import shouse_pkg::*;

    localparam int N_MUL      = 8;
    localparam int RST_CYCLES = 16;

    logic                clk = 1'b0;
    logic                rst;
    logic                busy;
    logic [BADDR_W-1:0]  baddr;
    logic                brnw;
    logic [DATA_W-1:0]   bdout;
    logic                bus_cs;
    logic [DATA_W-1:0]   bdin;
    logic                ram_cs;
    logic [DATA_W-1:0]   ram_dout = '0;
    logic                mcu_cs, mcu_rnw;
    logic [TRI_AW-1:0]   mcu_addr;
    logic [DATA_W-1:0]   mcu_dout, mcu_din;
    logic                snd_cs, snd_rnw;
    logic [TRI_AW-1:0]   snd_addr;
    logic [DATA_W-1:0]   snd_dout, snd_din;
    logic                prog_en, prog_wr;
    logic [KEY_AW-1:0]   prog_addr;
    logic [DATA_W-1:0]   prog_data;
    logic                cen_main, cen_snd, cen_mcu, snd_sel;

    // Work RAM model behind ram_cs, one clock read latency
    logic [DATA_W-1:0]   ram_mem [0:2**RAM_AW-1];

    // Operations loaded from the data file
    logic [7:0]          op_q[$];
    logic [7:0]          port_q[$];
    int                  idle_q[$];
    logic [15:0]         addr_q[$];
    logic [7:0]          data_q[$];
    logic [7:0]          exp_q[$];

    int                  n_checks;
    bit                  loaded;
    logic [31:0]         lfsr;

    shouse_sub u_dut(
        .clk(clk), .rst(rst), .busy(busy),
        .baddr(baddr), .brnw(brnw), .bdout(bdout), .bus_cs(bus_cs), .bdin(bdin),
        .ram_cs(ram_cs), .ram_dout(ram_dout),
        .mcu_cs(mcu_cs), .mcu_rnw(mcu_rnw), .mcu_addr(mcu_addr),
        .mcu_dout(mcu_dout), .mcu_din(mcu_din),
        .snd_cs(snd_cs), .snd_rnw(snd_rnw), .snd_addr(snd_addr),
        .snd_dout(snd_dout), .snd_din(snd_din),
        .prog_en(prog_en), .prog_wr(prog_wr), .prog_addr(prog_addr),
        .prog_data(prog_data),
        .cen_main(cen_main), .cen_snd(cen_snd), .cen_mcu(cen_mcu), .snd_sel(snd_sel)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (ram_cs) begin
            if (cen_main && !brnw) begin
                ram_mem[baddr[RAM_AW-1:0]] <= bdout;
            end
            ram_dout <= ram_mem[baddr[RAM_AW-1:0]];
        end
    end

    task automatic check_byte(input string name, input logic [7:0] exp,
                              input logic [7:0] act);
        n_checks++;
        assert (act === exp) else begin
            $display("[ERROR] %s: expected %02h, actual %02h", name, exp, act);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b[i] = lfsr[0];
        end
    endtask

    task automatic load_testdata();
        int          fd, code, idle, c;
        logic [7:0]  op, port, data, exp;
        logic [15:0] addr;
        fd = $fopen("shouse_testdata.txt", "r");
        assert (fd != 0) else begin
            $display("could not open shouse_testdata.txt");
            $display("sim failed");
            $fatal(1, "missing data file");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", op);
            if (code == 1 && op == "#") begin
                // Skip the rest of a comment line
                c = $fgetc(fd);
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if (code == 1) begin
                code = $fscanf(fd, " %c %d %h %h %h", port, idle, addr, data, exp);
                assert (code == 5 && (op == "W" || op == "R") &&
                        (port == "B" || port == "M" || port == "S" || port == "H")) else begin
                    $display("malformed line %0d in shouse_testdata.txt", op_q.size() + 1);
                    $display("sim failed");
                    $fatal(1, "bad data file");
                end
                op_q.push_back(op);
                port_q.push_back(port);
                idle_q.push_back(idle);
                addr_q.push_back(addr);
                data_q.push_back(data);
                exp_q.push_back(exp);
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_main_edge();
        do begin
            @(negedge clk);
        end while (!cen_main);
        @(posedge clk);
    endtask

    task automatic bus_access(input logic rnw, input logic [15:0] addr,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        logic ram_exp;
        // Work RAM window is 8 KiB from RAM_BASE
        ram_exp = (addr >= RAM_BASE) && (addr < RAM_BASE + 16'h2000);
        baddr  = addr;
        brnw   = rnw;
        bdout  = wdata;
        bus_cs = 1'b1;
        wait_main_edge();
        #2;
        rdata  = bdin;
        check_byte($sformatf("ram_cs for %04h", addr), 8'(ram_exp), 8'(ram_cs));
        bus_cs = 1'b0;
        brnw   = 1'b1;
    endtask

    // MCU or sound CPU access on port B, each in its own slot
    task automatic side_access(input logic is_snd, input logic rnw,
                               input logic [TRI_AW-1:0] addr, input logic [7:0] wdata,
                               output logic [7:0] rdata);
        if (is_snd) begin
            snd_addr = addr;
            snd_rnw  = rnw;
            snd_dout = wdata;
            snd_cs   = 1'b1;
        end else begin
            mcu_addr = addr;
            mcu_rnw  = rnw;
            mcu_dout = wdata;
            mcu_cs   = 1'b1;
        end
        do begin
            @(negedge clk);
        end while (is_snd ? !(cen_snd && snd_sel) : !(cen_mcu && !snd_sel));
        @(posedge clk);
        #2;
        rdata  = is_snd ? snd_din : mcu_din;
        snd_cs = 1'b0;
        mcu_cs = 1'b0;
    endtask

    task automatic header_write(input logic [KEY_AW-1:0] addr, input logic [7:0] data);
        prog_addr = addr;
        prog_data = data;
        prog_en   = 1'b1;
        prog_wr   = 1'b1;
        @(posedge clk);
        #2;
        prog_wr   = 1'b0;
        prog_en   = 1'b0;
    endtask

    task automatic replay();
        logic [7:0]  rd;
        logic [15:0] a;
        logic        rnw;
        string       name;
        for (int i = 0; i < op_q.size(); i++) begin
            repeat (idle_q[i]) begin
                @(posedge clk);
                #2;
            end
            a    = addr_q[i];
            rnw  = op_q[i] == "R";
            name = $sformatf("line %0d %c%c %04h", i + 1, op_q[i], port_q[i], a);
            case (port_q[i])
                "B":     bus_access(rnw, a, data_q[i], rd);
                "M":     side_access(1'b0, rnw, a[TRI_AW-1:0], data_q[i], rd);
                "S":     side_access(1'b1, rnw, a[TRI_AW-1:0], data_q[i], rd);
                default: header_write(a[KEY_AW-1:0], data_q[i]);
            endcase
            if (rnw) begin
                check_byte(name, exp_q[i], rd);
            end
        end
    endtask

    // Starts on the clock where rst falls
    task automatic check_enables();
        int last_main, last_mcu, last_snd;
        last_main = -1;
        last_mcu  = -1;
        last_snd  = -1;
        for (int k = 0; k < 32; k++) begin
            @(negedge clk);
            assert (!(cen_mcu && snd_sel)) else begin
                $display("cen_mcu pulsed while snd_sel gave port B to the sound CPU");
                $display("sim failed");
                $fatal(1, "slot overlap");
            end
            if (cen_main) begin
                if (last_main < 0) begin
                    check_byte("first cen_main after reset", 8'd3, 8'(k));
                end else begin
                    check_byte("cen_main spacing", 8'd4, 8'(k - last_main));
                end
                last_main = k;
            end
            // Sound runs two clocks ahead of main
            if (cen_snd) begin
                if (last_snd < 0) begin
                    check_byte("first cen_snd after reset", 8'd1, 8'(k));
                end else begin
                    check_byte("cen_snd spacing", 8'd4, 8'(k - last_snd));
                end
                last_snd = k;
            end
            if (cen_mcu) begin
                if (last_mcu < 0) begin
                    check_byte("first cen_mcu after reset", 8'd5, 8'(k));
                end else begin
                    check_byte("cen_mcu spacing", 8'd8, 8'(k - last_mcu));
                end
                last_mcu = k;
            end
        end
        @(posedge clk);
        #2;
    endtask

    task automatic check_multiplier();
        logic [7:0]  a, b, rd;
        logic [15:0] prod;
        for (int n = 0; n < N_MUL; n++) begin
            rand_byte(a);
            rand_byte(b);
            prod = 16'(a) * 16'(b);
            bus_access(1'b0, KEY_BASE + 16'(KEY_MULA_REG), a, rd);
            bus_access(1'b0, KEY_BASE + 16'(KEY_MULB_REG), b, rd);
            bus_access(1'b1, KEY_BASE + 16'(KEY_PLO_REG), 8'h00, rd);
            check_byte($sformatf("mul %0d low %02h*%02h", n, a, b), prod[7:0], rd);
            bus_access(1'b1, KEY_BASE + 16'(KEY_PHI_REG), 8'h00, rd);
            check_byte($sformatf("mul %0d high %02h*%02h", n, a, b), prod[15:8], rd);
        end
    endtask

    task automatic check_busy_stall();
        busy = 1'b1;
        for (int k = 0; k < 20; k++) begin
            @(negedge clk);
            assert (!cen_main) else begin
                $display("cen_main pulsed while busy was held high");
                $display("sim failed");
                $fatal(1, "busy ignored");
            end
        end
        @(posedge clk);
        #2;
        busy = 1'b0;
    endtask

    initial begin
        rst       = 1'b1;
        busy      = 1'b0;
        baddr     = '0;
        brnw      = 1'b1;
        bdout     = '0;
        bus_cs    = 1'b0;
        mcu_cs    = 1'b0;
        mcu_rnw   = 1'b1;
        mcu_addr  = '0;
        mcu_dout  = '0;
        snd_cs    = 1'b0;
        snd_rnw   = 1'b1;
        snd_addr  = '0;
        snd_dout  = '0;
        prog_en   = 1'b0;
        prog_wr   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        n_checks  = 0;
        lfsr      = 32'hb587;
        load_testdata();
        loaded    = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        check_enables();
        replay();
        check_multiplier();
        check_busy_stall();
        if (n_checks > 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("no checks were run");
            $display("sim failed");
            $fatal(1, "empty run");
        end
    end

    // Each access needs well under 64 clocks, even with idle cycles
    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = (op_q.size() + 4 * N_MUL + 2) * 64 + RST_CYCLES;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d clocks", limit);
        $display("sim failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- shouse_testdata.txt
# op (W/R) port (B main, M MCU, S sound, H header) idle-cycles addr data expect
# addr, data and expect in hex; expect is ignored for writes
W H 0 0000 a5 00
R B 0 5000 00 a5
W B 0 5001 3c 00
W B 1 5002 c3 00
W B 0 5003 5a 00
R B 0 5001 00 3c
R B 2 5002 00 c3
R B 0 5003 00 5a
W B 0 4010 11 00
W B 0 47ff 22 00
R M 0 0010 00 11
R S 0 0010 00 11
R M 1 07ff 00 22
R S 0 07ff 00 22
R B 0 4800 00 ff
W M 0 0100 66 00
W S 0 0101 77 00
W M 0 0102 88 00
W S 3 0103 99 00
R B 0 4100 00 66
R B 0 4101 00 77
R B 1 4102 00 88
R B 0 4103 00 99
W B 0 6000 de 00
W B 0 7fff ad 00
R B 0 6000 00 de
R B 1 7fff 00 ad
R B 0 0000 00 ff
R B 0 8000 00 ff
R B 0 5008 00 ff

//--- filelist.f
shouse_pkg.sv
shouse_cenloop.sv
shouse_decoder.sv
shouse_triram.sv
shouse_key.sv
shouse_sub.sv
shouse_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module shouse_tb -f filelist.f -o Vshouse_tb

run: compile
	./obj_dir/Vshouse_tb | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
